// File: bench/core_input.dat
// first word is the record count, then one record per line:
// instr pc rd we wdata next_pc (rd and wdata only matter when we is 1)
00000027
123450B7 00000100 01 1 12345000 00000104
00001117 00000104 02 1 00001104 00000108
FFB00193 00000108 03 1 FFFFFFFB 0000010C
0011A213 0000010C 04 1 00000001 00000110
0011B293 00000110 05 1 00000000 00000114
4011D313 00000114 06 1 FFFFFFFD 00000118
0041D393 00000118 07 1 0FFFFFFF 0000011C
0FF0C413 0000011C 08 1 123450FF 00000120
00319493 00000120 09 1 FFFFFFD8 00000124
00308533 00000124 0A 1 12344FFB 00000128
403085B3 00000128 0B 1 12345005 0000012C
00721633 0000012C 0C 1 80000000 00000130
004656B3 00000130 0D 1 40000000 00000134
40465733 00000134 0E 1 C0000000 00000138
0041A7B3 00000138 0F 1 00000001 0000013C
0041B833 0000013C 10 1 00000000 00000140
04102023 00000140 00 0 00000000 00000144
043002A3 00000144 00 0 00000000 00000148
04801323 00000148 00 0 00000000 0000014C
04002883 0000014C 11 1 12345000 00000150
04500903 00000150 12 1 FFFFFFFB 00000154
04504983 00000154 13 1 000000FB 00000158
04401A03 00000158 14 1 FFFFFB00 0000015C
04605A83 0000015C 15 1 000050FF 00000160
00F20863 00000160 00 0 00000000 00000170
00520863 00000170 00 0 00000000 00000174
FE521CE3 00000174 00 0 00000000 0000016C
0041C863 0000016C 00 0 00000000 0000017C
0041D863 0000017C 00 0 00000000 00000180
0041E863 00000180 00 0 00000000 00000184
00326863 00000184 00 0 00000000 00000194
0041F863 00000194 00 0 00000000 000001A4
020000EF 000001A4 01 1 000001A8 000001C4
00508B67 000001C4 16 1 000001C8 000001AC
02920013 000001AC 00 1 0000002A 000001B0
00000BB3 000001B0 17 1 00000000 000001B4
00706C13 000001B4 18 1 00000007 000001B8
FF00FC93 000001B8 19 1 000001A0 000001BC
0000000F 000001BC 00 0 00000000 000001C0

// File: bench/tb_core.sv
module tb_core
	import rv32i_types::*;
	import core_bus_types::*;
();

	localparam int MAX_REC = 64;

	logic      clk;
	logic      rst_n;
	logic      ins_req;
	ins_req_t  ins;
	logic      ins_ack;
	logic      mem_req;
	mem_req_t  mem;
	logic      mem_ack;
	rv32i_word mem_rdata;
	logic      ret_req;
	retire_t   ret;
	logic      ret_ack;

	rv32i_word stim [512]; // word 0 is the record count, then six words per record
	rv32i_word ram [256];
	integer    seed = 3057;
	int        n_rec;
	int        ret_count; // closed retire handshakes for the current record
	logic [6:0] cur_op; // opcode of the record in flight
	rv32i_word exp_pc;
	rv32i_word exp_rd;
	rv32i_word exp_we;
	rv32i_word exp_wdata;
	rv32i_word exp_next;

	core_top dut0 (
		.i_clk       (clk),
		.i_rst_n     (rst_n),
		.i_ins_req   (ins_req),
		.i_ins       (ins),
		.o_ins_ack   (ins_ack),
		.o_mem_req   (mem_req),
		.o_mem       (mem),
		.i_mem_ack   (mem_ack),
		.i_mem_rdata (mem_rdata),
		.o_ret_req   (ret_req),
		.o_ret       (ret),
		.i_ret_ack   (ret_ack)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped after the first error");
	endtask

	task automatic check_value(input string name, input rv32i_word exp_v, input rv32i_word act_v);
		assert (act_v === exp_v) else begin
			$display("ERR t=%0t %s expected %08h actual %08h", $time, name, exp_v, act_v);
			abort_run();
		end
	endtask

	task automatic wait_random();
		int n;
		n = $unsigned($random(seed)) % 4; // 0 to 3 cycles of back-pressure
		repeat (n) @(negedge clk);
	endtask

	task automatic run_record(input int r);
		logic [8:0] base;
		base      = 9'(1 + r * 6);
		exp_pc    = stim[base + 9'd1];
		exp_rd    = stim[base + 9'd2];
		exp_we    = stim[base + 9'd3];
		exp_wdata = stim[base + 9'd4];
		exp_next  = stim[base + 9'd5];
		cur_op    = stim[base][6:0];
		ret_count = 0;
		ins       = '{pc: exp_pc, instr: stim[base]};
		ins_req   = 1'b1;
		do @(negedge clk); while (ins_ack !== 1'b1);
		check_value("retire count at ins_ack", 32'd1, ret_count); // ack only after its own retire
		ins_req = 1'b0;
		do @(negedge clk); while (ins_ack !== 1'b0);
	endtask

	initial begin : memory_model
		logic [7:0] idx;
		for (int i = 0; i < 256; i++) begin
			ram[i] = '0;
		end
		forever begin
			@(negedge clk);
			if (mem_req) begin
				assert (mem.addr < 32'd1024) else begin
					$display("memory request at %08h is outside the 256-word model", mem.addr);
					abort_run();
				end
				assert (cur_op == 7'b0000011 || cur_op == 7'b0100011) else begin
					$display("memory request from an instruction that is neither a load nor a store");
					abort_run();
				end
				check_value("mem.we", {31'b0, cur_op == 7'b0100011}, {31'b0, mem.we});
				idx = mem.addr[9:2];
				wait_random();
				if (mem.we) begin
					if (mem.wmask[0]) ram[idx][7:0]   = mem.wdata[7:0];
					if (mem.wmask[1]) ram[idx][15:8]  = mem.wdata[15:8];
					if (mem.wmask[2]) ram[idx][23:16] = mem.wdata[23:16];
					if (mem.wmask[3]) ram[idx][31:24] = mem.wdata[31:24];
				end
				mem_rdata = ram[idx]; // held until the next request
				mem_ack   = 1'b1;
				do @(negedge clk); while (mem_req);
				wait_random();
				mem_ack = 1'b0;
			end
		end
	end

	initial begin : retire_model
		forever begin
			@(negedge clk);
			if (ret_req) begin
				check_value("ret.pc", exp_pc, ret.pc);
				check_value("ret.we", exp_we, {31'b0, ret.we});
				if (exp_we[0]) begin
					check_value("ret.rd", exp_rd, {27'b0, ret.rd});
					check_value("ret.wdata", exp_wdata, ret.wdata);
				end
				check_value("ret.next_pc", exp_next, ret.next_pc);
				wait_random();
				ret_ack = 1'b1;
				do @(negedge clk); while (ret_req);
				wait_random();
				ret_ack = 1'b0;
				ret_count++;
			end
		end
	end

	initial begin : watchdog
		wait (rst_n === 1'b1);
		repeat (n_rec * 40) @(posedge clk);
		$display("watchdog expired before %0d records had retired", n_rec);
		abort_run();
	end

	initial begin
		rst_n     = 1'b0;
		ins_req   = 1'b0;
		ins       = '0;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		ret_ack   = 1'b0;
		ret_count = 0;
		cur_op    = '0;
		exp_pc    = '0;
		exp_rd    = '0;
		exp_we    = '0;
		exp_wdata = '0;
		exp_next  = '0;
		$readmemh("bench/core_input.dat", stim);
		n_rec = stim[0];
		assert (n_rec >= 1 && n_rec <= MAX_REC) else begin
			$display("input file gives %0d records, which is not a usable count", n_rec);
			abort_run();
		end
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		for (int r = 0; r < n_rec; r++) begin
			run_record(r);
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: common/core_bus_types.sv
package core_bus_types;

	import rv32i_types::*;

	typedef struct packed {
		rv32i_word pc;
		rv32i_word instr;
	} ins_req_t;

	typedef struct packed {
		rv32i_word  addr;
		rv32i_word  wdata; // already placed on its byte lanes
		logic [3:0] wmask;
		logic       we;
	} mem_req_t;

	typedef struct packed {
		rv32i_word pc;
		rv32i_reg  rd;
		logic      we;
		rv32i_word wdata;
		rv32i_word next_pc;
	} retire_t;

endpackage

// File: common/rv32i_settings.svh
`ifndef RV32I_SETTINGS_SVH
`define RV32I_SETTINGS_SVH

`define RV_XLEN    32 // data and address width
`define RV_NREGS   32
`define RV_RADDR_W 5

`endif

// File: common/rv32i_types.sv
`include "rv32i_settings.svh"

package rv32i_types;

	typedef logic [`RV_XLEN-1:0] rv32i_word;
	typedef logic [`RV_RADDR_W-1:0] rv32i_reg;

	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32i_opcode;

	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3_t;

	typedef enum logic [2:0] {
		lb  = 3'b000,
		lh  = 3'b001,
		lw  = 3'b010,
		lbu = 3'b100,
		lhu = 3'b101
	} load_funct3_t;

	typedef enum logic [2:0] {
		sb = 3'b000,
		sh = 3'b001,
		sw = 3'b010
	} store_funct3_t;

	typedef enum logic [2:0] {
		add, sll, slt, sltu, axor, sr, aor, aand
	} arith_funct3_t;

	typedef enum logic [2:0] {
		alu_add, alu_sll, alu_sra, alu_sub, alu_xor, alu_srl, alu_or, alu_and
	} alu_ops;

	typedef enum logic {am1_rs1_out, am1_pc_out} alumux1_sel_t;
	typedef enum logic [2:0] {
		am2_i_imm, am2_u_imm, am2_b_imm, am2_s_imm, am2_j_imm, am2_rs2_out
	} alumux2_sel_t;
	typedef enum logic {cm_rs2_out, cm_i_imm} cmpmux_sel_t;
	typedef enum logic [3:0] {
		rf_alu_out, rf_br_en, rf_u_imm, rf_lw, rf_pc_plus4, rf_lb, rf_lbu, rf_lh, rf_lhu
	} regfilemux_sel_t;
	typedef enum logic {mm_pc_out, mm_alu_out} marmux_sel_t;

	typedef struct packed {
		rv32i_opcode     opcode;
		logic [2:0]      funct3;
		logic [6:0]      funct7;
		rv32i_word       i_imm;
		rv32i_word       s_imm;
		rv32i_word       b_imm;
		rv32i_word       u_imm;
		rv32i_word       j_imm;
		rv32i_reg        src1;
		rv32i_reg        src2;
		rv32i_reg        dest;
		alu_ops          aluop;
		branch_funct3_t  cmpop; // also serves slt and sltu
		alumux1_sel_t    alumux1_sel;
		alumux2_sel_t    alumux2_sel;
		cmpmux_sel_t     cmpmux_sel;
		regfilemux_sel_t regfilemux_sel;
		marmux_sel_t     marmux_sel;
		logic            load_regfile;
		logic            mem_read;
		logic            mem_write;
		logic [3:0]      wmask; // byte lanes before the address shift
	} control_word_t;

endpackage

// File: decode/control.sv
module control
	import rv32i_types::*;
(
	input  rv32i_word     i_data,
	output control_word_t o_cw
);

	always_comb begin
		o_cw.opcode = rv32i_opcode'(i_data[6:0]);
		o_cw.funct3 = i_data[14:12];
		o_cw.funct7 = i_data[31:25];

		o_cw.i_imm = {{21{i_data[31]}}, i_data[30:20]};
		o_cw.s_imm = {{21{i_data[31]}}, i_data[30:25], i_data[11:7]};
		o_cw.b_imm = {{20{i_data[31]}}, i_data[7], i_data[30:25], i_data[11:8], 1'b0};
		o_cw.u_imm = {i_data[31:12], 12'h000};
		o_cw.j_imm = {{12{i_data[31]}}, i_data[19:12], i_data[20], i_data[30:21], 1'b0};

		o_cw.src1 = i_data[19:15];
		o_cw.src2 = i_data[24:20];
		o_cw.dest = i_data[11:7];

		o_cw.aluop          = alu_add;
		o_cw.cmpop          = beq;
		o_cw.alumux1_sel    = am1_rs1_out;
		o_cw.alumux2_sel    = am2_i_imm;
		o_cw.cmpmux_sel     = cm_rs2_out;
		o_cw.regfilemux_sel = rf_alu_out;
		o_cw.marmux_sel     = mm_pc_out;
		o_cw.load_regfile   = 1'b0;
		o_cw.mem_read       = 1'b0;
		o_cw.mem_write      = 1'b0;
		o_cw.wmask          = 4'b0000;

		unique case (o_cw.opcode)
			op_lui: begin
				o_cw.load_regfile   = 1'b1;
				o_cw.regfilemux_sel = rf_u_imm;
			end
			op_auipc: begin
				o_cw.load_regfile = 1'b1;
				o_cw.alumux1_sel  = am1_pc_out;
				o_cw.alumux2_sel  = am2_u_imm;
			end
			op_jal: begin
				o_cw.load_regfile   = 1'b1;
				o_cw.regfilemux_sel = rf_pc_plus4;
				o_cw.alumux1_sel    = am1_pc_out;
				o_cw.alumux2_sel    = am2_j_imm; // target comes out of the alu
			end
			op_jalr: begin
				o_cw.load_regfile   = 1'b1;
				o_cw.regfilemux_sel = rf_pc_plus4;
			end
			op_br: begin
				o_cw.alumux1_sel = am1_pc_out;
				o_cw.alumux2_sel = am2_b_imm;
				o_cw.cmpop       = branch_funct3_t'(o_cw.funct3);
			end
			op_load: begin
				o_cw.load_regfile = 1'b1;
				o_cw.mem_read     = 1'b1;
				o_cw.marmux_sel   = mm_alu_out;
				unique case (load_funct3_t'(o_cw.funct3))
					lb:      o_cw.regfilemux_sel = rf_lb;
					lh:      o_cw.regfilemux_sel = rf_lh;
					lbu:     o_cw.regfilemux_sel = rf_lbu;
					lhu:     o_cw.regfilemux_sel = rf_lhu;
					default: o_cw.regfilemux_sel = rf_lw;
				endcase
			end
			op_store: begin
				o_cw.mem_write   = 1'b1;
				o_cw.marmux_sel  = mm_alu_out;
				o_cw.alumux2_sel = am2_s_imm;
				unique case (store_funct3_t'(o_cw.funct3))
					sb:      o_cw.wmask = 4'b0001;
					sh:      o_cw.wmask = 4'b0011;
					sw:      o_cw.wmask = 4'b1111;
					default: o_cw.wmask = 4'b0000;
				endcase
			end
			op_imm, op_reg: begin
				o_cw.load_regfile = 1'b1;
				if (o_cw.opcode == op_reg) begin
					o_cw.alumux2_sel = am2_rs2_out;
				end else begin
					o_cw.cmpmux_sel = cm_i_imm;
				end
				unique case (arith_funct3_t'(o_cw.funct3))
					add: begin
						if (o_cw.opcode == op_reg && o_cw.funct7[5]) begin
							o_cw.aluop = alu_sub;
						end
					end
					sll: o_cw.aluop = alu_sll;
					slt: begin
						o_cw.regfilemux_sel = rf_br_en;
						o_cw.cmpop          = blt;
					end
					sltu: begin
						o_cw.regfilemux_sel = rf_br_en;
						o_cw.cmpop          = bltu;
					end
					axor: o_cw.aluop = alu_xor;
					sr: begin
						// bit 30 picks arithmetic shift for both srai and sra
						if (o_cw.funct7[5]) begin
							o_cw.aluop = alu_sra;
						end else begin
							o_cw.aluop = alu_srl;
						end
					end
					aor:  o_cw.aluop = alu_or;
					aand: o_cw.aluop = alu_and;
				endcase
			end
			default: ; // unknown opcodes retire as a no-op
		endcase
	end

endmodule

// File: execute/exec_unit.sv
module exec_unit
	import rv32i_types::*;
	import core_bus_types::*;
(
	input  control_word_t i_cw,
	input  rv32i_word     i_pc,
	input  rv32i_word     i_rs1,
	input  rv32i_word     i_rs2,
	input  rv32i_word     i_mem_rdata,
	output mem_req_t      o_mem,
	output rv32i_word     o_wdata,
	output rv32i_word     o_next_pc
);

	rv32i_word alu_a;
	rv32i_word alu_b;
	rv32i_word alu_out;
	rv32i_word cmp_b;
	rv32i_word pc_plus4;
	rv32i_word addr;
	rv32i_word rdata_sh; // addressed byte moved down to lane 0
	logic      br_en;
	logic [1:0] off;

	assign alu_a    = (i_cw.alumux1_sel == am1_pc_out) ? i_pc : i_rs1;
	assign cmp_b    = (i_cw.cmpmux_sel == cm_i_imm) ? i_cw.i_imm : i_rs2;
	assign pc_plus4 = i_pc + 32'd4;

	always_comb begin
		case (i_cw.alumux2_sel)
			am2_u_imm:   alu_b = i_cw.u_imm;
			am2_b_imm:   alu_b = i_cw.b_imm;
			am2_s_imm:   alu_b = i_cw.s_imm;
			am2_j_imm:   alu_b = i_cw.j_imm;
			am2_rs2_out: alu_b = i_rs2;
			default:     alu_b = i_cw.i_imm;
		endcase
	end

	always_comb begin
		case (i_cw.aluop)
			alu_add: alu_out = alu_a + alu_b;
			alu_sll: alu_out = alu_a << alu_b[4:0];
			alu_sra: alu_out = rv32i_word'($signed(alu_a) >>> alu_b[4:0]);
			alu_sub: alu_out = alu_a - alu_b;
			alu_xor: alu_out = alu_a ^ alu_b;
			alu_srl: alu_out = alu_a >> alu_b[4:0];
			alu_or:  alu_out = alu_a | alu_b;
			alu_and: alu_out = alu_a & alu_b;
		endcase
	end

	always_comb begin
		case (i_cw.cmpop)
			beq:     br_en = (i_rs1 == cmp_b);
			bne:     br_en = (i_rs1 != cmp_b);
			blt:     br_en = ($signed(i_rs1) < $signed(cmp_b));
			bge:     br_en = ($signed(i_rs1) >= $signed(cmp_b));
			bltu:    br_en = (i_rs1 < cmp_b);
			bgeu:    br_en = (i_rs1 >= cmp_b);
			default: br_en = 1'b0;
		endcase
	end

	assign addr = (i_cw.marmux_sel == mm_alu_out) ? alu_out : i_pc;
	assign off  = addr[1:0];

	always_comb begin
		o_mem.addr  = addr;
		o_mem.wdata = i_rs2 << {off, 3'b000};
		o_mem.wmask = i_cw.wmask << off;
		o_mem.we    = i_cw.mem_write;
	end

	assign rdata_sh = i_mem_rdata >> {off, 3'b000};

	always_comb begin
		case (i_cw.regfilemux_sel)
			rf_br_en:    o_wdata = {31'b0, br_en};
			rf_u_imm:    o_wdata = i_cw.u_imm;
			rf_lw:       o_wdata = i_mem_rdata;
			rf_pc_plus4: o_wdata = pc_plus4;
			rf_lb:       o_wdata = {{24{rdata_sh[7]}}, rdata_sh[7:0]};
			rf_lbu:      o_wdata = {24'b0, rdata_sh[7:0]};
			rf_lh:       o_wdata = {{16{rdata_sh[15]}}, rdata_sh[15:0]};
			rf_lhu:      o_wdata = {16'b0, rdata_sh[15:0]};
			default:     o_wdata = alu_out;
		endcase
	end

	always_comb begin
		case (i_cw.opcode)
			op_jal:  o_next_pc = alu_out;
			op_jalr: o_next_pc = {alu_out[31:1], 1'b0};
			op_br:   o_next_pc = br_en ? alu_out : pc_plus4;
			default: o_next_pc = pc_plus4;
		endcase
	end

	// the decoder must never ask for a read and a write in one access
	always_comb begin
		assert (!(i_cw.mem_read === 1'b1 && i_cw.mem_write === 1'b1));
	end

endmodule

// File: files.f
+incdir+common
common/rv32i_types.sv
common/core_bus_types.sv
decode/control.sv
execute/exec_unit.sv
logic/regfile.sv
logic/hs_sender.sv
logic/issue_ctrl.sv
logic/core_top.sv
bench/tb_core.sv

// File: logic/core_top.sv
module core_top
	import rv32i_types::*;
	import core_bus_types::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_ins_req,
	input  ins_req_t  i_ins,
	output logic      o_ins_ack,
	output logic      o_mem_req,
	output mem_req_t  o_mem,
	input  logic      i_mem_ack,
	input  rv32i_word i_mem_rdata,
	output logic      o_ret_req,
	output retire_t   o_ret,
	input  logic      i_ret_ack
);

	ins_req_t      cur;
	control_word_t cw;
	rv32i_word     rs1;
	rv32i_word     rs2;
	rv32i_word     wdata;
	rv32i_word     next_pc;
	mem_req_t      mem_next;
	retire_t       ret_next;
	logic          mem_load;
	logic          mem_done;
	logic          rf_we;
	logic          ret_load;
	logic          ret_done;

	assign ret_next = '{pc: cur.pc, rd: cw.dest, we: rf_we, wdata: wdata, next_pc: next_pc};

	control dec0 (
		.i_data (cur.instr),
		.o_cw   (cw)
	);

	regfile rf0 (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_we       (rf_we),
		.i_rd_addr  (cw.dest),
		.i_rd_data  (wdata),
		.i_rs1_addr (cw.src1),
		.i_rs2_addr (cw.src2),
		.o_rs1      (rs1),
		.o_rs2      (rs2)
	);

	exec_unit ex0 (
		.i_cw        (cw),
		.i_pc        (cur.pc),
		.i_rs1       (rs1),
		.i_rs2       (rs2),
		.i_mem_rdata (i_mem_rdata),
		.o_mem       (mem_next),
		.o_wdata     (wdata),
		.o_next_pc   (next_pc)
	);

	issue_ctrl ctrl0 (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_ins_req  (i_ins_req),
		.i_ins      (i_ins),
		.i_cw       (cw),
		.i_mem_done (mem_done),
		.i_ret_done (ret_done),
		.o_ins_ack  (o_ins_ack),
		.o_cur      (cur),
		.o_mem_load (mem_load),
		.o_rf_we    (rf_we),
		.o_ret_load (ret_load)
	);

	hs_sender #(.T_PAYLOAD(mem_req_t)) mem_sender (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_load    (mem_load),
		.i_payload (mem_next),
		.i_ack     (i_mem_ack),
		.o_req     (o_mem_req),
		.o_payload (o_mem),
		.o_done    (mem_done)
	);

	hs_sender #(.T_PAYLOAD(retire_t)) ret_sender (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_load    (ret_load),
		.i_payload (ret_next),
		.i_ack     (i_ret_ack),
		.o_req     (o_ret_req),
		.o_payload (o_ret),
		.o_done    (ret_done)
	);

endmodule

// File: logic/hs_sender.sv
module hs_sender #(
	parameter type T_PAYLOAD = logic
) (
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_load,
	input  T_PAYLOAD i_payload,
	input  logic     i_ack,
	output logic     o_req,
	output T_PAYLOAD o_payload,
	output logic     o_done
);

	typedef enum logic [1:0] {S_IDLE, S_REQ, S_ACK_LOW} state_t;

	state_t state;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state  <= S_IDLE;
			o_req  <= 1'b0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (i_load) begin
						o_req <= 1'b1;
						state <= S_REQ;
					end
				end
				S_REQ: begin
					if (i_ack) begin
						o_req <= 1'b0;
						state <= S_ACK_LOW;
					end
				end
				S_ACK_LOW: begin
					if (!i_ack) begin // receiver has closed the transaction
						o_done <= 1'b1;
						state  <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_load) begin
			o_payload <= i_payload;
		end
	end

	assert property (@(posedge i_clk) disable iff (!i_rst_n) i_load |-> state == S_IDLE);

	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_req && $past(o_req) |-> $stable(o_payload));

endmodule

// File: logic/issue_ctrl.sv
module issue_ctrl
	import rv32i_types::*;
	import core_bus_types::*;
(
	input  logic          i_clk,
	input  logic          i_rst_n,
	input  logic          i_ins_req,
	input  ins_req_t      i_ins,
	input  control_word_t i_cw,
	input  logic          i_mem_done,
	input  logic          i_ret_done,
	output logic          o_ins_ack,
	output ins_req_t      o_cur,
	output logic          o_mem_load,
	output logic          o_rf_we,
	output logic          o_ret_load
);

	typedef enum logic [2:0] {ST_IDLE, ST_EXEC, ST_MEM, ST_RETIRE, ST_ACK} state_t;

	state_t state;
	logic   ret_busy; // retire event already handed to the sender
	logic   is_mem;

	assign is_mem = i_cw.mem_read | i_cw.mem_write;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= ST_IDLE;
			ret_busy <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_ins_req) begin
						state <= ST_EXEC;
					end
				end
				ST_EXEC: state <= is_mem ? ST_MEM : ST_RETIRE;
				ST_MEM: begin
					if (i_mem_done) begin
						state <= ST_RETIRE;
					end
				end
				ST_RETIRE: begin
					ret_busy <= 1'b1;
					if (i_ret_done) begin
						ret_busy <= 1'b0;
						state    <= ST_ACK;
					end
				end
				ST_ACK: begin
					if (!i_ins_req) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == ST_IDLE && i_ins_req) begin
			o_cur <= i_ins;
		end
	end

	assign o_mem_load = (state == ST_EXEC) && is_mem;
	assign o_ret_load = (state == ST_RETIRE) && !ret_busy;
	assign o_rf_we    = o_ret_load && i_cw.load_regfile; // same edge the retire payload is taken
	assign o_ins_ack  = (state == ST_ACK);

endmodule

// File: logic/regfile.sv
`include "rv32i_settings.svh"

module regfile
	import rv32i_types::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_we,
	input  rv32i_reg  i_rd_addr,
	input  rv32i_word i_rd_data,
	input  rv32i_reg  i_rs1_addr,
	input  rv32i_reg  i_rs2_addr,
	output rv32i_word o_rs1,
	output rv32i_word o_rs2
);

	rv32i_word regs [`RV_NREGS];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && (i_rd_addr != '0)) begin // x0 stays zero from reset
			regs[i_rd_addr] <= i_rd_data;
		end
	end

	assign o_rs1 = regs[i_rs1_addr];
	assign o_rs2 = regs[i_rs2_addr];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# compile the core testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_core -f files.f -o tb_core

# the simulator's own exit status is ignored here, the log decides
./obj_dir/tb_core 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation finished without failures"
exit 0
